//--- hdl/lx_pkg.sv
// shared cache definitions: line geometry, message codes and address views
`default_nettype none

package lx_pkg;

	localparam int ADDRESS_WIDTH = 12;
	localparam int OFFSET_BITS = 2;	// word within a line
	localparam int INDEX_BITS = 6;
	localparam int TAG_BITS = ADDRESS_WIDTH - INDEX_BITS - OFFSET_BITS;
	localparam int DATA_WIDTH = 8;
	localparam int LINE_WIDTH = DATA_WIDTH << OFFSET_BITS;
	localparam int NUM_WAYS = 2;
	localparam int NUM_SETS = 1 << INDEX_BITS;

	typedef logic [LINE_WIDTH-1:0] lx_line_t;

	// same 12 bits, seen whole or split for the tag lookup
	typedef union packed {
		logic [ADDRESS_WIDTH-1:0] flat;
		struct packed {
			logic [TAG_BITS-1:0] tag;
			logic [INDEX_BITS-1:0] index;
			logic [OFFSET_BITS-1:0] offset;
		} fields;
	} lx_addr_t;

	typedef enum logic [1:0] {
		REQ_NONE = 2'd0,
		REQ_READ = 2'd1,
		REQ_WRITE_BACK = 2'd2
	} lx_req_msg_t;

	typedef enum logic [1:0] {
		RSP_NONE = 2'd0,
		RSP_DATA = 2'd1,	// read answered, line on rsp_data
		RSP_DONE = 2'd2	// write-back taken
	} lx_rsp_msg_t;

	typedef enum logic [1:0] {
		MEM_REQ_NONE = 2'd0,
		MEM_REQ_READ = 2'd1,
		MEM_REQ_WRITE_BACK = 2'd2
	} lx_mem_req_t;

	typedef enum logic [1:0] {
		MEM_RSP_NONE = 2'd0,
		MEM_RSP_SENT = 2'd1,
		MEM_RSP_READY = 2'd2
	} lx_mem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/lx_port_arbiter.sv
// upper port arbiter, round-robin grant and response return to the granted port
`timescale 1ns/1ns
`default_nettype none

module lx_port_arbiter import lx_pkg::*; #(
	parameter int NUM_PORTS = 4
) (
	input wire clock,
	input wire reset,
	input wire ready,
	input wire lx_req_msg_t [NUM_PORTS-1:0] req_msg,
	input wire lx_addr_t [NUM_PORTS-1:0] req_address,
	input wire lx_line_t [NUM_PORTS-1:0] req_data,
	output lx_rsp_msg_t [NUM_PORTS-1:0] rsp_msg,
	output lx_line_t [NUM_PORTS-1:0] rsp_data,
	output logic sel_valid,
	output lx_req_msg_t sel_msg,
	output lx_addr_t sel_address,
	output lx_line_t sel_data,
	input wire done,
	input wire lx_rsp_msg_t done_msg,
	input wire lx_line_t done_data
);

	localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	localparam logic [1:0] ARB_IDLE = 2'd0;
	localparam logic [1:0] ARB_BUSY = 2'd1;
	localparam logic [1:0] ARB_RESP = 2'd2;	// response cycle, port drops its request

	logic [1:0] state;
	logic [PORT_BITS-1:0] grant_port;	// granted port, or the last one served
	logic [PORT_BITS-1:0] next_port;
	logic next_found;

	// first requester after the last one served
	always_comb begin
		next_port = grant_port;
		next_found = 1'b0;
		for (int k = 1; k <= NUM_PORTS; k++) begin
			if (!next_found && req_msg[(int'(grant_port) + k) % NUM_PORTS] != REQ_NONE) begin
				next_found = 1'b1;
				next_port = PORT_BITS'((int'(grant_port) + k) % NUM_PORTS);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ARB_IDLE;
			grant_port <= PORT_BITS'(NUM_PORTS - 1);	// port 0 goes first
			for (int p = 0; p < NUM_PORTS; p++)
				rsp_msg[p] <= RSP_NONE;
		end else begin
			for (int p = 0; p < NUM_PORTS; p++)
				rsp_msg[p] <= RSP_NONE;
			case (state)
				ARB_IDLE: begin
					if (ready && next_found) begin
						grant_port <= next_port;
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (done) begin
						rsp_msg[grant_port] <= done_msg;
						state <= ARB_RESP;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ARB_BUSY && done)
			rsp_data[grant_port] <= done_data;
	end

	assign sel_valid = (state == ARB_BUSY);
	assign sel_msg = req_msg[grant_port];
	assign sel_address = req_address[grant_port];
	assign sel_data = req_data[grant_port];

endmodule

`default_nettype wire

//--- hdl/lx_tag_array.sv
// tag store for both ways of every set, with registered hit and victim lookup
`timescale 1ns/1ns
`default_nettype none

module lx_tag_array import lx_pkg::*; (
	input wire clock,
	input wire reset,
	input wire lx_addr_t lookup_address,
	input wire update_en,
	input wire update_way,
	input wire [TAG_BITS-1:0] update_tag,
	input wire update_dirty,
	input wire touch_en,
	output logic ready,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output logic victim_dirty,
	output logic [TAG_BITS-1:0] victim_tag
);

	logic [NUM_WAYS-1:0] valid [NUM_SETS];
	logic [NUM_WAYS-1:0] dirty [NUM_SETS];
	logic [TAG_BITS-1:0] tags [NUM_SETS][NUM_WAYS];
	logic lru [NUM_SETS];	// way to replace next
	logic [INDEX_BITS-1:0] sweep_index;
	logic [INDEX_BITS-1:0] lookup_set;
	logic [NUM_WAYS-1:0] way_match;
	logic pick;

	assign lookup_set = lookup_address.fields.index;

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++)
			way_match[w] = valid[lookup_set][w] && tags[lookup_set][w] == lookup_address.fields.tag;
		// empty way before the LRU one
		if (!valid[lookup_set][0])
			pick = 1'b0;
		else if (!valid[lookup_set][1])
			pick = 1'b1;
		else
			pick = lru[lookup_set];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ready <= 1'b0;
			sweep_index <= '0;
		end else if (!ready) begin
			sweep_index <= sweep_index + 1'b1;
			if (sweep_index == INDEX_BITS'(NUM_SETS - 1))
				ready <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!ready) begin
			valid[sweep_index] <= '0;
			dirty[sweep_index] <= '0;
			lru[sweep_index] <= 1'b0;
		end else begin
			if (update_en) begin
				valid[lookup_set][update_way] <= 1'b1;
				dirty[lookup_set][update_way] <= update_dirty;
				tags[lookup_set][update_way] <= update_tag;
			end
			if (touch_en)
				lru[lookup_set] <= ~update_way;	// other way is now the older
		end
	end

	always_ff @(posedge clock) begin
		hit <= |way_match;
		hit_way <= way_match[1];
		victim_way <= pick;
		victim_dirty <= valid[lookup_set][pick] && dirty[lookup_set][pick];
		victim_tag <= tags[lookup_set][pick];
	end

endmodule

`default_nettype wire

//--- hdl/lx_data_array.sv
// line storage for both ways of every set, read through an output register
`timescale 1ns/1ns
`default_nettype none

module lx_data_array import lx_pkg::*; (
	input wire clock,
	input wire [INDEX_BITS-1:0] index,
	input wire way,
	input wire write_en,
	input wire lx_line_t write_line,
	output lx_line_t read_line
);

	// set and way form the row address
	lx_line_t lines [NUM_SETS * NUM_WAYS];

	always_ff @(posedge clock) begin
		if (write_en)
			lines[{index, way}] <= write_line;
		read_line <= lines[{index, way}];	// old contents on a same-cycle write
	end

endmodule

`default_nettype wire

//--- hdl/lx_controller.sv
// cache controller, sequencing lookups, hits, dirty evictions and memory fills
`timescale 1ns/1ns
`default_nettype none

module lx_controller import lx_pkg::*; (
	input wire clock,
	input wire reset,
	input wire sel_valid,
	input wire lx_req_msg_t sel_msg,
	input wire lx_addr_t sel_address,
	input wire lx_line_t sel_data,
	output logic done,
	output lx_rsp_msg_t done_msg,
	output lx_line_t done_data,
	output lx_addr_t lookup_address,
	input wire hit,
	input wire hit_way,
	input wire victim_way,
	input wire victim_dirty,
	input wire [TAG_BITS-1:0] victim_tag,
	output logic update_en,
	output logic update_way,
	output logic [TAG_BITS-1:0] update_tag,
	output logic update_dirty,
	output logic touch_en,
	output logic [INDEX_BITS-1:0] data_index,
	output logic data_way,
	output logic data_write_en,
	output lx_line_t data_write_line,
	input wire lx_line_t read_line,
	output lx_mem_req_t mem_req,
	output lx_addr_t mem_address,
	output lx_line_t mem_data,
	input wire lx_mem_rsp_t mem_rsp,
	input wire lx_line_t mem_rsp_data
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_LOOKUP = 3'd1;
	localparam logic [2:0] S_SERVE = 3'd2;
	localparam logic [2:0] S_EVICT = 3'd3;
	localparam logic [2:0] S_FILL = 3'd4;
	localparam logic [2:0] S_RELOOK = 3'd5;	// lets the filled tag reach the lookup register

	logic [2:0] state;
	logic way_q;
	logic way_sel;
	logic is_wb;
	logic issue;
	logic wb_ack;
	logic fill_ack;
	logic store_now;

	assign is_wb = (sel_msg == REQ_WRITE_BACK);
	assign way_sel = (state == S_LOOKUP) ? (hit ? hit_way : victim_way) : way_q;
	assign issue = (mem_req == MEM_REQ_NONE) && (mem_rsp == MEM_RSP_NONE);
	assign wb_ack = (mem_req == MEM_REQ_WRITE_BACK) && (mem_rsp == MEM_RSP_READY);
	assign fill_ack = (state == S_FILL) && (mem_req == MEM_REQ_READ) && (mem_rsp == MEM_RSP_SENT);

	// upper write-back lands once its way is free
	assign store_now = is_wb && ((state == S_LOOKUP && (hit || !victim_dirty)) ||
		(state == S_EVICT && wb_ack));

	assign lookup_address = sel_address;
	assign update_way = way_sel;
	assign update_tag = sel_address.fields.tag;
	assign data_index = sel_address.fields.index;
	assign data_way = way_sel;
	assign done_data = read_line;

	always_comb begin
		done = 1'b0;
		done_msg = RSP_NONE;
		update_en = 1'b0;
		update_dirty = 1'b0;
		touch_en = 1'b0;
		data_write_en = 1'b0;
		data_write_line = sel_data;
		if (store_now) begin
			done = 1'b1;
			done_msg = RSP_DONE;
			update_en = 1'b1;
			update_dirty = 1'b1;
			touch_en = 1'b1;
			data_write_en = 1'b1;
		end else if (fill_ack) begin
			update_en = 1'b1;	// filled clean
			data_write_en = 1'b1;
			data_write_line = mem_rsp_data;
		end else if (state == S_LOOKUP && hit) begin
			touch_en = 1'b1;
		end else if (state == S_SERVE) begin
			done = 1'b1;
			done_msg = RSP_DATA;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			mem_req <= MEM_REQ_NONE;
		end else begin
			case (state)
				S_IDLE: begin
					if (sel_valid)
						state <= S_LOOKUP;
				end
				S_LOOKUP: begin
					if (store_now)
						state <= S_IDLE;
					else if (hit)
						state <= S_SERVE;	// data read under way this cycle
					else if (victim_dirty)
						state <= S_EVICT;
					else
						state <= S_FILL;
				end
				S_SERVE: state <= S_IDLE;
				S_EVICT: begin
					if (issue) begin
						mem_req <= MEM_REQ_WRITE_BACK;
					end else if (wb_ack) begin
						mem_req <= MEM_REQ_NONE;
						state <= is_wb ? S_IDLE : S_FILL;
					end
				end
				S_FILL: begin
					if (issue) begin
						mem_req <= MEM_REQ_READ;
					end else if (fill_ack) begin
						mem_req <= MEM_REQ_NONE;
						state <= S_RELOOK;
					end
				end
				S_RELOOK: state <= S_LOOKUP;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_LOOKUP)
			way_q <= way_sel;
		if (state == S_EVICT && issue) begin
			mem_address.fields.tag <= victim_tag;
			mem_address.fields.index <= sel_address.fields.index;
			mem_address.fields.offset <= '0;	// lines are written whole
			mem_data <= read_line;
		end
		if (state == S_FILL && issue)
			mem_address.flat <= sel_address.flat;
	end

endmodule

`default_nettype wire

//--- hdl/lx_cache.sv
// shared second-level cache top, four upper ports in front of one memory
`timescale 1ns/1ns
`default_nettype none

module lx_cache import lx_pkg::*; #(
	parameter int NUM_PORTS = 4
) (
	input wire clock,
	input wire reset,
	input wire lx_req_msg_t [NUM_PORTS-1:0] req_msg,
	input wire lx_addr_t [NUM_PORTS-1:0] req_address,
	input wire lx_line_t [NUM_PORTS-1:0] req_data,
	output lx_rsp_msg_t [NUM_PORTS-1:0] rsp_msg,
	output lx_line_t [NUM_PORTS-1:0] rsp_data,
	output lx_mem_req_t mem_req,
	output lx_addr_t mem_address,
	output lx_line_t mem_data,
	input wire lx_mem_rsp_t mem_rsp,
	input wire lx_line_t mem_rsp_data
);

	logic ready;
	logic sel_valid;
	lx_req_msg_t sel_msg;
	lx_addr_t sel_address;
	lx_line_t sel_data;
	logic done;
	lx_rsp_msg_t done_msg;
	lx_line_t done_data;
	lx_addr_t lookup_address;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;
	logic update_en;
	logic update_way;
	logic [TAG_BITS-1:0] update_tag;
	logic update_dirty;
	logic touch_en;
	logic [INDEX_BITS-1:0] data_index;
	logic data_way;
	logic data_write_en;
	lx_line_t data_write_line;
	lx_line_t read_line;

	lx_port_arbiter #(
		.NUM_PORTS(NUM_PORTS)
	) arbiter_inst (
		.clock(clock),
		.reset(reset),
		.ready(ready),
		.req_msg(req_msg),
		.req_address(req_address),
		.req_data(req_data),
		.rsp_msg(rsp_msg),
		.rsp_data(rsp_data),
		.sel_valid(sel_valid),
		.sel_msg(sel_msg),
		.sel_address(sel_address),
		.sel_data(sel_data),
		.done(done),
		.done_msg(done_msg),
		.done_data(done_data)
	);

	lx_controller controller_inst (
		.clock(clock),
		.reset(reset),
		.sel_valid(sel_valid),
		.sel_msg(sel_msg),
		.sel_address(sel_address),
		.sel_data(sel_data),
		.done(done),
		.done_msg(done_msg),
		.done_data(done_data),
		.lookup_address(lookup_address),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.update_en(update_en),
		.update_way(update_way),
		.update_tag(update_tag),
		.update_dirty(update_dirty),
		.touch_en(touch_en),
		.data_index(data_index),
		.data_way(data_way),
		.data_write_en(data_write_en),
		.data_write_line(data_write_line),
		.read_line(read_line),
		.mem_req(mem_req),
		.mem_address(mem_address),
		.mem_data(mem_data),
		.mem_rsp(mem_rsp),
		.mem_rsp_data(mem_rsp_data)
	);

	lx_tag_array tag_array_inst (
		.clock(clock),
		.reset(reset),
		.lookup_address(lookup_address),
		.update_en(update_en),
		.update_way(update_way),
		.update_tag(update_tag),
		.update_dirty(update_dirty),
		.touch_en(touch_en),
		.ready(ready),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag)
	);

	lx_data_array data_array_inst (
		.clock(clock),
		.index(data_index),
		.way(data_way),
		.write_en(data_write_en),
		.write_line(data_write_line),
		.read_line(read_line)
	);

endmodule

`default_nettype wire

//--- tb/lx_mem_model.sv
// behavioral main memory, answers line reads and write-backs after a short delay
`timescale 1ns/1ns
`default_nettype none

module lx_mem_model import lx_pkg::*; (
	input wire clock,
	input wire reset,
	input wire lx_mem_req_t mem_req,
	input wire lx_addr_t mem_address,
	input wire lx_line_t mem_data,
	output lx_mem_rsp_t mem_rsp,
	output lx_line_t mem_rsp_data
);

	localparam logic [31:0] SEED = 32'h7f5f_f445;
	localparam int NUM_LINES = 1 << (ADDRESS_WIDTH - OFFSET_BITS);

	lx_line_t lines [NUM_LINES];
	logic [31:0] delay_state;
	int wait_count;
	logic busy;
	wire [ADDRESS_WIDTH-OFFSET_BITS-1:0] line_index = mem_address.flat[ADDRESS_WIDTH-1:OFFSET_BITS];

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// line n holds the lfsr stepped n times
	initial begin
		logic [31:0] s;
		s = SEED;
		for (int i = 0; i < NUM_LINES; i++) begin
			lines[i] = s;
			s = lfsr_step(s);
		end
		delay_state = SEED;
		busy = 1'b0;
		wait_count = 0;
		mem_rsp = MEM_RSP_NONE;
		mem_rsp_data = '0;
	end

	always @(negedge clock) begin
		if (reset) begin
			mem_rsp <= MEM_RSP_NONE;
			busy = 1'b0;
		end else if (mem_rsp != MEM_RSP_NONE) begin
			if (mem_req == MEM_REQ_NONE)
				mem_rsp <= MEM_RSP_NONE;	// request dropped, answer seen
		end else if (mem_req != MEM_REQ_NONE) begin
			if (!busy) begin
				busy = 1'b1;
				delay_state = lfsr_step(delay_state);
				wait_count = int'(delay_state[0]);
				delay_state = lfsr_step(delay_state);
				wait_count = wait_count * 2 + int'(delay_state[0]);	// 0 to 3 extra cycles
			end else if (wait_count > 0) begin
				wait_count--;
			end else begin
				busy = 1'b0;
				if (mem_req == MEM_REQ_WRITE_BACK) begin
					lines[line_index] = mem_data;
					mem_rsp <= MEM_RSP_READY;
				end else begin
					mem_rsp_data <= lines[line_index];
					mem_rsp <= MEM_RSP_SENT;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_lx_cache.sv
// testbench for the shared cache, covering reset, misses, hits, eviction and arbitration
`timescale 1ns/1ns
`default_nettype none

module tb_lx_cache import lx_pkg::*; ();

	localparam int NUM_PORTS = 4;
	localparam logic [31:0] SEED = 32'h7f5f_f445;
	localparam int RSP_LIMIT = 300;
	localparam int SWEEP_CYCLES = 64;

	logic clock;
	logic reset;
	lx_req_msg_t [NUM_PORTS-1:0] req_msg;
	lx_addr_t [NUM_PORTS-1:0] req_address;
	lx_line_t [NUM_PORTS-1:0] req_data;
	lx_rsp_msg_t [NUM_PORTS-1:0] rsp_msg;
	lx_line_t [NUM_PORTS-1:0] rsp_data;
	lx_mem_req_t mem_req;
	lx_addr_t mem_address;
	lx_line_t mem_data;
	lx_mem_rsp_t mem_rsp;
	lx_line_t mem_rsp_data;

	lx_line_t written [int];	// last line written back per address
	int rsp_log [$];	// ports in the order answered
	lx_mem_req_t mem_kind_log [$];
	logic [ADDRESS_WIDTH-1:0] mem_addr_log [$];
	lx_line_t mem_data_log [$];
	lx_mem_req_t mem_req_last;
	int checks;
	int errors;
	int tests;
	int failed_tests;
	int test_errors;
	int last_port;
	int latency;
	logic timed_out;

	lx_cache #(
		.NUM_PORTS(NUM_PORTS)
	) lx_cache_inst (
		.clock(clock),
		.reset(reset),
		.req_msg(req_msg),
		.req_address(req_address),
		.req_data(req_data),
		.rsp_msg(rsp_msg),
		.rsp_data(rsp_data),
		.mem_req(mem_req),
		.mem_address(mem_address),
		.mem_data(mem_data),
		.mem_rsp(mem_rsp),
		.mem_rsp_data(mem_rsp_data)
	);

	lx_mem_model mem_model_inst (
		.clock(clock),
		.reset(reset),
		.mem_req(mem_req),
		.mem_address(mem_address),
		.mem_data(mem_data),
		.mem_rsp(mem_rsp),
		.mem_rsp_data(mem_rsp_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// records every response and each new memory request
	always @(negedge clock) begin
		for (int p = 0; p < NUM_PORTS; p++)
			if (rsp_msg[p] != RSP_NONE)
				rsp_log.push_back(p);
		if (mem_req != MEM_REQ_NONE && mem_req_last == MEM_REQ_NONE) begin
			mem_kind_log.push_back(mem_req);
			mem_addr_log.push_back(mem_address.flat);
			mem_data_log.push_back(mem_data);
		end
		mem_req_last = mem_req;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// written data if any, else the lfsr stepped once per line address
	function automatic lx_line_t expected_line(input logic [ADDRESS_WIDTH-1:0] address);
		logic [31:0] s;
		s = SEED;
		if (written.exists(int'(address)))
			return written[int'(address)];
		for (int i = 0; i < int'(address[ADDRESS_WIDTH-1:OFFSET_BITS]); i++)
			s = lfsr_step(s);
		return s;
	endfunction

	function automatic logic any_response();
		logic seen;
		seen = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++)
			if (rsp_msg[p] != RSP_NONE)
				seen = 1'b1;
		return seen;
	endfunction

	function automatic logic quiet();
		return (mem_req == MEM_REQ_NONE) && !any_response();
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic check_true(input logic condition, input string what);
		checks++;
		assert (condition) else begin
			$display("%0t %s", $time, what);
			errors++;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic clear_logs();
		rsp_log.delete();
		mem_kind_log.delete();
		mem_addr_log.delete();
		mem_data_log.delete();
	endtask

	task automatic send_request(input int port, input lx_req_msg_t msg,
			input logic [ADDRESS_WIDTH-1:0] address, input lx_line_t data);
		req_msg[port] = msg;
		req_address[port].flat = address;
		req_data[port] = data;
	endtask

	// waits for the port's response, then drops its request
	task automatic wait_response(input int port);
		int count;
		count = 0;
		do begin
			@(negedge clock);
			count++;
		end while (rsp_msg[port] == RSP_NONE && count < RSP_LIMIT);
		latency = count;
		if (rsp_msg[port] == RSP_NONE) begin
			$display("%0t port %0d got no response in %0d cycles", $time, port, RSP_LIMIT);
			errors++;
			timed_out = 1'b1;
		end
		req_msg[port] = REQ_NONE;
	endtask

	task automatic collect_response(input int port, input lx_req_msg_t msg,
			input logic [ADDRESS_WIDTH-1:0] address, input lx_line_t data);
		wait_response(port);
		if (msg == REQ_WRITE_BACK) begin
			check_value($sformatf("rsp_msg[%0d]", port), rsp_msg[port], RSP_DONE);
			written[int'(address)] = data;
		end else begin
			check_value($sformatf("rsp_msg[%0d]", port), rsp_msg[port], RSP_DATA);
			check_value($sformatf("rsp_data[%0d]", port), rsp_data[port], expected_line(address));
		end
		last_port = port;
	endtask

	task automatic transact(input int port, input lx_req_msg_t msg,
			input logic [ADDRESS_WIDTH-1:0] address, input lx_line_t data);
		send_request(port, msg, address, data);
		collect_response(port, msg, address, data);
		idle_cycles(2);
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_errors) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	task automatic test_reset();
		for (int i = 0; i < 8; i++) begin
			@(negedge clock);
			check_true(quiet(), "response or memory request seen before any request");
		end
		send_request(1, REQ_READ, 12'h104, '0);
		for (int i = 0; i < SWEEP_CYCLES; i++) begin	// issued mid sweep
			@(negedge clock);
			check_true(!any_response(), "request answered within 64 cycles of the sweep");
		end
		collect_response(1, REQ_READ, 12'h104, '0);
		idle_cycles(2);
		finish_test("reset");
	endtask

	task automatic test_read_miss();
		clear_logs();
		transact(2, REQ_READ, 12'h208, '0);
		check_value("memory requests", mem_kind_log.size(), 1);
		if (mem_kind_log.size() == 1) begin
			check_value("mem_req", mem_kind_log[0], MEM_REQ_READ);
			check_value("mem_address", mem_addr_log[0], 12'h208);
		end
		check_value("responses", rsp_log.size(), 1);
		foreach (rsp_log[i])
			check_value("responding port", rsp_log[i], 2);
		finish_test("read miss");
	endtask

	task automatic test_hits();
		clear_logs();
		transact(0, REQ_WRITE_BACK, 12'h30c, 32'hc0de_0003);
		check_value("write-back latency", latency, 3);
		transact(3, REQ_READ, 12'h30c, '0);
		check_value("read hit latency", latency, 4);
		check_value("memory requests", mem_kind_log.size(), 0);
		finish_test("hits");
	endtask

	// tags 1 and 2 dirty in set 5, tag 1 touched, tag 3 evicts tag 2
	task automatic test_eviction();
		clear_logs();
		transact(0, REQ_WRITE_BACK, 12'h114, 32'ha1a1_0005);
		transact(1, REQ_WRITE_BACK, 12'h214, 32'hb2b2_0005);
		transact(2, REQ_READ, 12'h114, '0);
		transact(3, REQ_READ, 12'h314, '0);
		check_value("memory requests", mem_kind_log.size(), 2);
		if (mem_kind_log.size() == 2) begin
			check_value("mem_req", mem_kind_log[0], MEM_REQ_WRITE_BACK);
			check_value("mem_address", mem_addr_log[0], 12'h214);
			check_value("mem_data", mem_data_log[0], 32'hb2b2_0005);
			check_value("mem_req", mem_kind_log[1], MEM_REQ_READ);
			check_value("mem_address", mem_addr_log[1], 12'h314);
		end
		finish_test("dirty eviction");
	endtask

	task automatic test_arbitration();
		int first;
		clear_logs();
		first = (last_port + 1) % NUM_PORTS;
		send_request(0, REQ_READ, 12'h420, '0);
		send_request(1, REQ_READ, 12'h524, '0);
		send_request(2, REQ_READ, 12'h30c, '0);
		send_request(3, REQ_READ, 12'h628, '0);
		fork
			collect_response(0, REQ_READ, 12'h420, '0);
			collect_response(1, REQ_READ, 12'h524, '0);
			collect_response(2, REQ_READ, 12'h30c, '0);
			collect_response(3, REQ_READ, 12'h628, '0);
		join
		idle_cycles(2);
		check_value("responses", rsp_log.size(), NUM_PORTS);
		foreach (rsp_log[i])
			check_value("responding port", rsp_log[i], (first + i) % NUM_PORTS);
		finish_test("arbitration");
	endtask

	initial begin
		reset = 1'b1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			req_msg[p] = REQ_NONE;
			req_address[p].flat = '0;
			req_data[p] = '0;
		end
		checks = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		test_errors = 0;
		latency = 0;
		last_port = NUM_PORTS - 1;
		timed_out = 1'b0;
		mem_req_last = MEM_REQ_NONE;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		test_reset();
		if (!timed_out)
			test_read_miss();
		if (!timed_out)
			test_hits();
		if (!timed_out)
			test_eviction();
		if (!timed_out)
			test_arbitration();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks,
			errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hdl/lx_pkg.sv
hdl/lx_port_arbiter.sv
hdl/lx_tag_array.sv
hdl/lx_data_array.sv
hdl/lx_controller.sv
hdl/lx_cache.sv
tb/lx_mem_model.sv
tb/tb_lx_cache.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_lx_cache
FILELIST = vlog.f
OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
